/* hw/capture_params.svh */
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// ----------------------------------------------------------------------
// sample word and centring unit sizes
// ----------------------------------------------------------------------
`define CAP_ANTENNAS   24 // one-bit antennas per sample word

// phase and delay share one field width
`define CAP_PBITS      4
`define CAP_SBITS      5 // antenna select, covers 0..31

// taps of the delay line, 2**CAP_PBITS
`define CAP_DEPTH      16

// consecutive equal phases before lock is declared
`define CAP_LOCK_COUNT 4

`endif

/* hw/capture_pkg.sv */
`include "capture_params.svh"

package capture_pkg;

   // one raw sample, one bit per antenna
   typedef logic [`CAP_ANTENNAS-1:0] sample_t;

   // ----------------------------------------------------------------------
   // host write word, two views picked by address
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic                  capture; // capture enable
      logic                  centre;  // run centring unit
      logic                  restart; // pulse only, never stored
      logic                  spare;
      logic [`CAP_PBITS-1:0] delay;   // sample delay, 0..15
   } capture_cfg_t;

   typedef struct packed {
      logic                  debug;  // fake data instead of antennas
      logic                  shift;  // lfsr source
      logic                  count;  // up-counter source
      logic [`CAP_SBITS-1:0] select; // antenna for phase measurement
   } source_cfg_t;

   typedef union packed {
      capture_cfg_t cap; // address 0
      source_cfg_t  src; // address 1
   } cfg_word_u;

   // full control set as seen by the datapath
   typedef struct packed {
      logic                  capture;
      logic                  centre;
      logic                  restart; // single-cycle pulse
      logic                  spare;   // follows the host word
      logic [`CAP_PBITS-1:0] delay;
      logic                  debug;
      logic                  shift;
      logic                  count;
      logic [`CAP_SBITS-1:0] select;
   } ctrl_t;

   typedef struct packed {
      logic                  locked;
      logic                  invalid; // lock lost since restart
      logic [`CAP_PBITS-1:0] phase;
   } align_status_t;

   typedef logic [1:0] host_addr_t;

   localparam host_addr_t ADDR_CAPTURE = 2'd0;
   localparam host_addr_t ADDR_SOURCE  = 2'd1;
   localparam host_addr_t ADDR_STATUS  = 2'd2;

endpackage

/* hw/capture_regs.sv */
`timescale 1ns/1ps

module capture_regs
(
   input  logic                         clock_x_i,
   input  logic                         rst_i,
   input  logic                         host_wr_i,    // write strobe
   input  capture_pkg::host_addr_t      host_addr_i,
   input  capture_pkg::cfg_word_u       host_wdata_i,
   output logic [7:0]                   host_rdata_o, // registered read word
   input  capture_pkg::align_status_t   status_i,     // retimed status
   output capture_pkg::ctrl_t           ctrl_o
);
   import capture_pkg::*;

   capture_cfg_t cap_q; // restart bit kept at zero
   source_cfg_t  src_q;
   logic         restart_q;
   logic [7:0]   rdata_q;

   // ----------------------------------------------------------------------
   // config writes and restart pulse
   // ----------------------------------------------------------------------
   always_ff @(posedge clock_x_i)
   begin
      if (rst_i)
      begin
         cap_q     <= '0;
         src_q     <= '0;
         restart_q <= 1'b0;
      end
      else
      begin
         // pulse lasts one cycle, only on a capture-word write
         restart_q <= host_wr_i && (host_addr_i == ADDR_CAPTURE)
                      && host_wdata_i.cap.restart;
         if (host_wr_i && host_addr_i == ADDR_CAPTURE)
         begin
            cap_q         <= host_wdata_i.cap; // capture view
            cap_q.restart <= 1'b0;
         end
         if (host_wr_i && host_addr_i == ADDR_SOURCE)
            src_q <= host_wdata_i.src; // source view
      end
   end

   // ----------------------------------------------------------------------
   // read mux, registered
   // ----------------------------------------------------------------------
   always_ff @(posedge clock_x_i)
   begin
      if (rst_i)
         rdata_q <= '0;
      else
      begin
         case (host_addr_i)
            ADDR_CAPTURE: rdata_q <= cap_q;
            ADDR_SOURCE:  rdata_q <= src_q;
            ADDR_STATUS:  rdata_q <= {2'b00, status_i}; // zero-extend
            default:      rdata_q <= '0;
         endcase
      end
   end

   assign host_rdata_o = rdata_q;

   // flatten both config words into the control set
   assign ctrl_o = '{capture: cap_q.capture, centre: cap_q.centre, restart: restart_q,
                     spare: cap_q.spare, delay: cap_q.delay, debug: src_q.debug,
                     shift: src_q.shift, count: src_q.count, select: src_q.select};

endmodule

/* hw/capture_control.sv */
`timescale 1ns/1ps

module capture_control
(
   input  logic                       clock_x_i,
   input  logic                       rst_i,
   input  capture_pkg::ctrl_t         ctrl_i,   // from host registers
   output capture_pkg::ctrl_t         ctrl_o,   // to sampling datapath
   input  capture_pkg::align_status_t status_i, // from centring unit
   output capture_pkg::align_status_t status_o  // back to host registers
);
   import capture_pkg::*;

   // ----------------------------------------------------------------------
   // paired retiming stages with _t first and then _x or _b
   // ----------------------------------------------------------------------
   ctrl_t         ctrl_t_q;   // host -> sample side
   ctrl_t         ctrl_x_q;
   align_status_t status_q;   // sample -> host side
   align_status_t status_b_q;

   // control chain fixing the datapath latency at two edges
   always_ff @(posedge clock_x_i)
   begin
      if (rst_i)
      begin
         ctrl_t_q <= '0;
         ctrl_x_q <= '0; // restart pulse stays low
      end
      else
      begin
         // capture, centring and debug settings together
         {ctrl_x_q, ctrl_t_q} <= {ctrl_t_q, ctrl_i};
      end
   end

   // status chain
   always_ff @(posedge clock_x_i)
   begin
      if (rst_i)
      begin
         status_q   <= '0;
         status_b_q <= '0;
      end
      else
      begin
         // locked, invalid and phase
         {status_b_q, status_q} <= {status_q, status_i};
      end
   end

   assign ctrl_o   = ctrl_x_q;
   assign status_o = status_b_q;

endmodule

/* hw/fake_data_gen.sv */
`timescale 1ns/1ps

module fake_data_gen
(
   input  logic                 clock_x_i,
   input  logic                 rst_i,
   input  logic                 debug_i, // advance only while set
   input  logic                 shift_i, // lfsr mode, wins over count
   input  logic                 count_i, // up-counter mode
   output capture_pkg::sample_t fake_o
);
   import capture_pkg::*;

   // galois feedback for taps 24, 23, 22 and 17
   localparam sample_t LFSR_TAPS = 24'hE1_0000;

   sample_t fake_q;

   // one lfsr step, shifting toward bit 0
   function automatic sample_t lfsr_step(input sample_t s);
      sample_t n;
      n = s >> 1;
      if (s[0])
         n = n ^ LFSR_TAPS;
      return n;
   endfunction

   // ----------------------------------------------------------------------
   // debug word register
   // ----------------------------------------------------------------------
   always_ff @(posedge clock_x_i)
   begin
      if (rst_i)
         fake_q <= '0;
      else if (debug_i)
      begin
         if (shift_i)
            fake_q <= (fake_q == '0) ? sample_t'(1) : lfsr_step(fake_q); // seed
         else if (count_i)
            fake_q <= fake_q + sample_t'(1);
         else
            fake_q <= '0; // no source picked
      end
   end

   assign fake_o = fake_q;

endmodule

/* hw/capture_delay.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module capture_delay
(
   input  logic                  clock_x_i,
   input  logic                  rst_i,
   input  capture_pkg::sample_t  antenna_i, // live antenna word
   input  capture_pkg::sample_t  fake_i,    // debug word
   input  logic                  debug_i,   // picks fake_i
   input  logic                  capture_i, // output qualifier
   input  logic [`CAP_PBITS-1:0] delay_i,   // 0..15 samples
   output capture_pkg::sample_t  data_o,
   output logic                  valid_o
);
   import capture_pkg::*;

   sample_t taps [`CAP_DEPTH]; // tap 0 holds the newest sample
   sample_t src;
   sample_t data_q;
   logic    valid_q;

   assign src = debug_i ? fake_i : antenna_i;

   // ----------------------------------------------------------------------
   // delay line, payload only
   // ----------------------------------------------------------------------
   always_ff @(posedge clock_x_i)
   begin
      taps[0] <= src;
      for (int i = 1; i < `CAP_DEPTH; i++)
         taps[i] <= taps[i-1];
   end

   // chosen tap, held while capture is off
   always_ff @(posedge clock_x_i)
   begin
      if (rst_i)
      begin
         data_q  <= '0;
         valid_q <= 1'b0;
      end
      else
      begin
         valid_q <= capture_i;
         if (capture_i)
            data_q <= taps[delay_i]; // delay+1 edges after sampling
      end
   end

   assign data_o  = data_q;
   assign valid_o = valid_q;

endmodule

/* hw/phase_align.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module phase_align
(
   input  logic                       clock_x_i,
   input  logic                       rst_i,
   input  capture_pkg::sample_t       antenna_i,
   input  logic                       centre_i,  // run the window counter
   input  logic [`CAP_SBITS-1:0]      select_i,  // antenna under test
   input  logic                       restart_i, // clear lock state
   output capture_pkg::align_status_t status_o
);
   import capture_pkg::*;

   localparam int MBITS = $clog2(`CAP_LOCK_COUNT + 1);

   logic [`CAP_PBITS-1:0] win_q;   // 16-sample window position
   logic [MBITS-1:0]      match_q; // 0 means no phase seen yet
   logic [MBITS-1:0]      match_nxt;
   logic                  bit_now;
   logic                  bit_q;
   logic                  rise;
   align_status_t         stat_q;

   // out-of-range select reads as a quiet antenna
   assign bit_now = (select_i < `CAP_ANTENNAS) ? antenna_i[select_i] : 1'b0;
   assign rise    = centre_i && bit_now && !bit_q;

   // ----------------------------------------------------------------------
   // match counting, saturates at the lock count
   // ----------------------------------------------------------------------
   always_comb
   begin
      if (match_q != '0 && win_q == stat_q.phase)
         match_nxt = (match_q == MBITS'(`CAP_LOCK_COUNT)) ? match_q : match_q + 1'b1;
      else
         match_nxt = MBITS'(1); // new phase starts a fresh run
   end

   always_ff @(posedge clock_x_i)
   begin
      if (rst_i)
         bit_q <= 1'b0;
      else
         bit_q <= bit_now;
   end

   always_ff @(posedge clock_x_i)
   begin
      if (rst_i || restart_i)
      begin
         win_q   <= '0;
         match_q <= '0;
         stat_q  <= '0;
      end
      else
      begin
         if (centre_i)
            win_q <= win_q + 1'b1; // wraps every 16 samples
         if (rise)
         begin
            stat_q.phase <= win_q;
            match_q      <= match_nxt;
            if (match_nxt >= MBITS'(`CAP_LOCK_COUNT))
               stat_q.locked <= 1'b1;
            else if (stat_q.locked)
            begin
               stat_q.locked  <= 1'b0; // phase moved under lock
               stat_q.invalid <= 1'b1; // sticky until restart
            end
         end
      end
   end

   assign status_o = stat_q;

endmodule

/* hw/capture_top.sv */
`timescale 1ns/1ps

module capture_top
(
   input  logic                    clock_x_i,
   input  logic                    rst_i,
   input  logic                    host_wr_i,
   input  capture_pkg::host_addr_t host_addr_i,
   input  capture_pkg::cfg_word_u  host_wdata_i,
   output logic [7:0]              host_rdata_o,
   input  capture_pkg::sample_t    antenna_i,
   output capture_pkg::sample_t    data_o,
   output logic                    valid_o
);
   import capture_pkg::*;

   // ----------------------------------------------------------------------
   // host side and retiming
   // ----------------------------------------------------------------------
   ctrl_t         regs_ctrl;    // straight from the registers
   ctrl_t         cap_ctrl;     // two edges later
   align_status_t align_status; // from centring unit
   align_status_t host_status;  // two edges later
   sample_t       fake_data;

   capture_regs u_regs (
      .clock_x_i    (clock_x_i),
      .rst_i        (rst_i),
      .host_wr_i    (host_wr_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .host_rdata_o (host_rdata_o),
      .status_i     (host_status),
      .ctrl_o       (regs_ctrl)
   );

   capture_control u_control (
      .clock_x_i (clock_x_i),
      .rst_i     (rst_i),
      .ctrl_i    (regs_ctrl),
      .ctrl_o    (cap_ctrl),
      .status_i  (align_status),
      .status_o  (host_status)
   );

   // ----------------------------------------------------------------------
   // sampling datapath
   // ----------------------------------------------------------------------
   fake_data_gen u_fake (
      .clock_x_i (clock_x_i),
      .rst_i     (rst_i),
      .debug_i   (cap_ctrl.debug),
      .shift_i   (cap_ctrl.shift),
      .count_i   (cap_ctrl.count),
      .fake_o    (fake_data)
   );

   capture_delay u_delay (
      .clock_x_i (clock_x_i),
      .rst_i     (rst_i),
      .antenna_i (antenna_i),
      .fake_i    (fake_data),
      .debug_i   (cap_ctrl.debug),
      .capture_i (cap_ctrl.capture),
      .delay_i   (cap_ctrl.delay),
      .data_o    (data_o),
      .valid_o   (valid_o)
   );

   phase_align u_align (
      .clock_x_i (clock_x_i),
      .rst_i     (rst_i),
      .antenna_i (antenna_i), // live antennas, not the debug word
      .centre_i  (cap_ctrl.centre),
      .select_i  (cap_ctrl.select),
      .restart_i (cap_ctrl.restart),
      .status_o  (align_status)
   );

endmodule

/* testbench/capture_tb.sv */
`timescale 1ns/1ps
`include "capture_params.svh"

module capture_tb;
   import capture_pkg::*;

   localparam int M_IDLE   = 0; // antennas held at zero
   localparam int M_RAND   = 1;
   localparam int M_SQUARE = 2; // period-16 wave on the selected antenna
   localparam int C_DELAY  = 1; // data_o against sample history
   localparam int C_HOLD   = 2; // capture off and data_o frozen
   localparam int C_COUNT  = 3;
   localparam int C_LFSR   = 4;
   localparam int S_NONE   = 0;
   localparam int S_FLAGS  = 1; // locked and invalid only
   localparam int S_FULL   = 2; // phase as well
   localparam int NROWS    = 10;
   localparam int HDEPTH   = 32;

   typedef struct packed {
      capture_cfg_t cap;
      source_cfg_t  src;
      logic [1:0]   mode;
      logic [3:0]   offset;   // square wave edge offset
      logic [7:0]   cycles;   // stream cycles after the writes
      logic [2:0]   chk;
      logic [1:0]   stat_chk;
      logic         exp_locked;
      logic         exp_invalid;
   } row_t;

   logic       clock_x;
   logic       rst;
   logic       host_wr;
   host_addr_t host_addr;
   cfg_word_u  host_wdata;
   logic [7:0] host_rdata;
   sample_t    antenna;
   sample_t    data;
   logic       valid;

   row_t        rows [NROWS];
   sample_t     hist [HDEPTH]; // hist[0] sampled at the latest edge
   logic [31:0] rng;
   int          edge_cnt;
   int          restart_edge;  // edge where restart clears the window
   int          cyc_cnt;
   int          cyc_limit;
   int          cur_mode;
   int          cur_off;
   int          cur_sel;

   capture_top u_dut (
      .clock_x_i    (clock_x),
      .rst_i        (rst),
      .host_wr_i    (host_wr),
      .host_addr_i  (host_addr),
      .host_wdata_i (host_wdata),
      .host_rdata_o (host_rdata),
      .antenna_i    (antenna),
      .data_o       (data),
      .valid_o      (valid)
   );

   initial
   begin
      clock_x = 1'b0;
      forever #2 clock_x = ~clock_x; // 4 ns period
   end

   // watchdog with the limit taken from the table
   initial
   begin
      cyc_cnt = 0;
      forever
      begin
         @(posedge clock_x);
         cyc_cnt++;
         if (cyc_cnt > cyc_limit)
         begin
            $display("timeout after %0d cycles, the test sequence never ended", cyc_cnt);
            abort_run();
         end
      end
   end

   // ----------------------------------------------------------------------
   // reference models
   // ----------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic sample_t next_count(input sample_t s);
      return s + 24'd1; // wraps at 2**24
   endfunction

   // galois step toward bit 0 with taps 24 23 22 17
   function automatic sample_t lfsr_next(input sample_t s);
      sample_t mask;
      mask     = '0;
      mask[23] = 1'b1;
      mask[22] = 1'b1;
      mask[21] = 1'b1;
      mask[16] = 1'b1;
      return s[0] ? ((s >> 1) ^ mask) : (s >> 1);
   endfunction

   // rises where (e - off) mod 16 is 0 and stays high for 8 edges
   function automatic logic square_bit(input int e, input int off);
      return ((e - off) & 15) < 8;
   endfunction

   // window counter reads k-1 at the k-th edge after the restart edge
   function automatic logic [`CAP_PBITS-1:0] expected_phase(input int off, input int r_edge);
      return (off - r_edge - 1) & (`CAP_DEPTH - 1);
   endfunction

   // ----------------------------------------------------------------------
   // failure handling and compare tasks
   // ----------------------------------------------------------------------
   task automatic abort_run();
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_sample(input sample_t got, input sample_t exp, input string name);
      if (got !== exp)
      begin
         $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_valid(input logic got, input bit exp, input string name);
      if (got !== exp)
      begin
         $display("ERR %0t ns %s got %b expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_rdata(input logic [7:0] got, input logic [7:0] exp, input string name);
      if (got !== exp)
      begin
         $display("ERR %0t ns %s got %h expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_status(input align_status_t got, input align_status_t exp,
                               input bit with_phase);
      if (!with_phase)
         exp.phase = got.phase; // phase undefined after a disturbed edge
      if (got !== exp)
      begin
         $display("ERR %0t ns host_rdata_o status got %h expected %h", $time, got, exp);
         abort_run();
      end
   endtask

   // ----------------------------------------------------------------------
   // table construction
   // ----------------------------------------------------------------------
   function automatic capture_cfg_t cap_word(input bit capture, input bit centre,
                                             input bit restart, input bit spare,
                                             input int delay);
      capture_cfg_t c;
      c.capture = capture;
      c.centre  = centre;
      c.restart = restart;
      c.spare   = spare;
      c.delay   = delay[`CAP_PBITS-1:0];
      return c;
   endfunction

   function automatic source_cfg_t src_word(input bit debug, input bit shift,
                                            input bit count, input int sel);
      source_cfg_t s;
      s.debug  = debug;
      s.shift  = shift;
      s.count  = count;
      s.select = sel[`CAP_SBITS-1:0];
      return s;
   endfunction

   function automatic row_t make_row(input capture_cfg_t cap, input source_cfg_t src,
                                     input int mode, input int off, input int cycles,
                                     input int chk, input int st, input bit lk, input bit inv);
      row_t r;
      r.cap         = cap;
      r.src         = src;
      r.mode        = mode[1:0];
      r.offset      = off[3:0];
      r.cycles      = cycles[7:0];
      r.chk         = chk[2:0];
      r.stat_chk    = st[1:0];
      r.exp_locked  = lk;
      r.exp_invalid = inv;
      return r;
   endfunction

   task automatic load_table();
      int n;
      rows[0] = make_row(cap_word(1, 0, 0, 0, 0), src_word(0, 0, 0, 0),
                         M_RAND, 0, 40, C_DELAY, S_NONE, 0, 0);
      rows[1] = make_row(cap_word(1, 0, 0, 0, 5), src_word(0, 0, 0, 0),
                         M_RAND, 0, 40, C_DELAY, S_NONE, 0, 0);
      rows[2] = make_row(cap_word(1, 0, 0, 0, 15), src_word(0, 0, 0, 0),
                         M_RAND, 0, 40, C_DELAY, S_NONE, 0, 0);
      rows[3] = make_row(cap_word(0, 0, 0, 0, 15), src_word(0, 0, 0, 0),
                         M_RAND, 0, 20, C_HOLD, S_NONE, 0, 0);
      rows[4] = make_row(cap_word(1, 0, 0, 1, 0), src_word(1, 0, 1, 0),
                         M_IDLE, 0, 40, C_COUNT, S_NONE, 0, 0);
      rows[5] = make_row(cap_word(1, 0, 0, 0, 3), src_word(1, 1, 1, 3),
                         M_IDLE, 0, 40, C_LFSR, S_NONE, 0, 0);
      // rows 6 and 7 last 80 cycles each so the second phase is one greater
      rows[6] = make_row(cap_word(1, 1, 1, 0, 2), src_word(0, 0, 0, 7),
                         M_SQUARE, 3, 76, C_DELAY, S_FULL, 1, 0);
      rows[7] = make_row(cap_word(1, 1, 1, 0, 2), src_word(0, 0, 0, 7),
                         M_SQUARE, 4, 76, C_DELAY, S_FULL, 1, 0);
      rows[8] = make_row(cap_word(1, 1, 0, 0, 2), src_word(0, 0, 0, 7),
                         M_SQUARE, 9, 24, C_DELAY, S_FLAGS, 0, 1); // edge moved without restart
      rows[9] = make_row(cap_word(1, 1, 1, 0, 2), src_word(0, 0, 0, 7),
                         M_SQUARE, 4, 76, C_DELAY, S_FULL, 1, 0);
      cyc_limit = 200 + 6; // reset and reset-state reads
      for (n = 0; n < NROWS; n++)
         cyc_limit += rows[n].cycles + 4;
   endtask

   // ----------------------------------------------------------------------
   // one clock edge and then the next antenna word
   // ----------------------------------------------------------------------
   task automatic step_cycle();
      sample_t w;
      int      k;
      @(posedge clock_x);
      for (k = HDEPTH - 1; k > 0; k--)
         hist[k] = hist[k-1];
      hist[0] = antenna; // word the DUT just took
      edge_cnt++;
      #1;
      rng = xorshift32(rng);
      w   = rng[`CAP_ANTENNAS-1:0];
      if (cur_mode == M_SQUARE)
         w[cur_sel] = square_bit(edge_cnt + 1, cur_off);
      antenna = (cur_mode == M_IDLE) ? '0 : w;
   endtask

   task automatic run_row(input row_t r);
      capture_cfg_t  cap_rb;
      align_status_t exp_st;
      sample_t       held;
      sample_t       prev;
      int            d;
      int            i;
      cur_mode = r.mode;
      cur_off  = r.offset;
      cur_sel  = r.src.select;
      d        = r.cap.delay;
      host_wr         = 1'b1;
      host_addr       = ADDR_CAPTURE;
      host_wdata.cap  = r.cap;
      step_cycle();
      if (r.cap.restart)
         restart_edge = edge_cnt + 3; // pulse reaches cap_ctrl after W+2 and acts at W+3
      host_addr       = ADDR_SOURCE;
      host_wdata.src  = r.src;
      step_cycle();
      host_wr   = 1'b0;
      host_addr = ADDR_CAPTURE;
      step_cycle();
      cap_rb         = r.cap;
      cap_rb.restart = 1'b0; // never stored
      check_rdata(host_rdata, cap_rb, "host_rdata_o capture word");
      host_addr = ADDR_SOURCE;
      step_cycle();
      check_rdata(host_rdata, r.src, "host_rdata_o source word");
      host_addr = ADDR_STATUS; // status polled through the stream
      for (i = 0; i < r.cycles; i++)
      begin
         step_cycle();
         case (r.chk)
            C_DELAY:
               if (i > `CAP_DEPTH)
               begin
                  check_valid(valid, 1'b1, "valid_o");
                  check_sample(data, hist[d+1], "data_o"); // taken delay+1 edges ago
               end
            C_HOLD:
            begin
               check_valid(valid, 1'b0, "valid_o");
               if (i == 0)
                  held = data;
               else
                  check_sample(data, held, "data_o");
            end
            C_COUNT:
               if (i > `CAP_DEPTH)
               begin
                  check_valid(valid, 1'b1, "valid_o");
                  check_sample(data, next_count(prev), "data_o");
               end
            C_LFSR:
               if (i > `CAP_DEPTH)
               begin
                  check_valid(valid, 1'b1, "valid_o");
                  check_sample(data, lfsr_next(prev), "data_o");
               end
            default:
               ;
         endcase
         prev = data;
      end
      if (r.stat_chk != S_NONE)
      begin
         exp_st.locked  = r.exp_locked;
         exp_st.invalid = r.exp_invalid;
         exp_st.phase   = expected_phase(r.offset, restart_edge);
         check_rdata({host_rdata[7:6], 6'd0}, 8'h00, "host_rdata_o upper bits");
         check_status(host_rdata[5:0], exp_st, r.stat_chk == S_FULL);
      end
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      int n;
      rst          = 1'b1;
      host_wr      = 1'b0;
      host_addr    = ADDR_CAPTURE;
      host_wdata   = '0;
      antenna      = '0;
      rng          = 32'd78; // xorshift seed
      edge_cnt     = 0;
      restart_edge = 0;
      cur_mode     = M_IDLE;
      cur_off      = 0;
      cur_sel      = 0;
      for (n = 0; n < HDEPTH; n++)
         hist[n] = '0;
      load_table();
      repeat (3) step_cycle(); // reset for three cycles
      rst = 1'b0;
      step_cycle();
      check_valid(valid, 1'b0, "valid_o");
      check_sample(data, '0, "data_o");
      check_rdata(host_rdata, 8'h00, "host_rdata_o addr 0");
      host_addr = ADDR_SOURCE;
      step_cycle();
      check_rdata(host_rdata, 8'h00, "host_rdata_o addr 1");
      host_addr = ADDR_STATUS;
      step_cycle();
      check_rdata(host_rdata, 8'h00, "host_rdata_o addr 2");
      for (n = 0; n < NROWS; n++)
         run_row(rows[n]);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

/* list.f */
+incdir+hw
hw/capture_pkg.sv
hw/capture_regs.sv
hw/capture_control.sv
hw/fake_data_gen.sv
hw/capture_delay.sv
hw/phase_align.sv
hw/capture_top.sv
testbench/capture_tb.sv

/* Bender.yml */
package:
  name: capture_frontend

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/capture_pkg.sv
      - hw/capture_regs.sv
      - hw/capture_control.sv
      - hw/fake_data_gen.sv
      - hw/capture_delay.sv
      - hw/phase_align.sv
      - hw/capture_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - testbench/capture_tb.sv
